//--- Makefile
# Verilator build and run for the load/store unit testbench

BIN = obj_dir/Vlsu_tb

.PHONY: compile run clean

compile: $(BIN)

$(BIN): lsu_top.f src/*.sv src/*.svh verification/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f lsu_top.f -o Vlsu_tb

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- lsu_top.f
+incdir+src
src/lsu_pkg.sv
src/lsu_req_queue.sv
src/lsu_issue_ctrl.sv
src/lsu_store_merge.sv
src/lsu_load_align.sv
src/lsu_top.sv
verification/lsu_tb.sv

//--- src/lsu_defs.svh
// geometry and RISC-V encodings, a 64-byte line and 64-bit data are assumed throughout
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// cache line and datapath geometry
`define LSU_LINE_BYTES   64
`define LSU_XLEN         64
`define LSU_OFFSET_W     6     // log2 of line bytes
`define LSU_ADDR_W       32

// request queue depth, kept a power of two
`define LSU_QUEUE_DEPTH  8

// major opcodes
`define LSU_OP_LOAD      7'b0000011
`define LSU_OP_STORE     7'b0100011

// load funct3
`define LSU_F3_LB        3'b000
`define LSU_F3_LH        3'b001
`define LSU_F3_LW        3'b010
`define LSU_F3_LD        3'b011
`define LSU_F3_LBU       3'b100
`define LSU_F3_LHU       3'b101
`define LSU_F3_LWU       3'b110

// store funct3, low two bits give the log2 size
`define LSU_F3_SB        3'b000
`define LSU_F3_SH        3'b001
`define LSU_F3_SW        3'b010
`define LSU_F3_SD        3'b011

`endif

//--- src/lsu_issue_ctrl.sv
// zero-cycle issue decision that assumes each stream head holds still until its rd_en
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_issue_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             head_valid,
    input  lsu_pkg::inst_t   head_inst,
    input  logic             pkt1_empty,
    input  logic             pkt1_miss,
    input  logic             vpkt_empty,
    input  logic             vpkt_miss,
    input  lsu_pkg::vidx_t   vpkt_vidx,
    input  logic             pkt2_empty,
    output logic             issue,
    output logic             is_load,
    output logic             is_store,
    output lsu_pkg::funct3_t funct3,
    output logic             pkt1_rd_en,
    output logic             vpkt_rd_en,
    output logic             pkt2_rd_en,
    output logic             victim_cam_en,
    output lsu_pkg::vidx_t   victim_cam_index
);

    logic [6:0]             opcode;
    lsu_pkg::issue_state_t  state;
    lsu_pkg::issue_state_t  state_q;

    assign opcode   = head_inst[6:0];
    assign funct3   = head_inst[14:12];
    assign is_load  = (opcode == `LSU_OP_LOAD);
    assign is_store = (opcode == `LSU_OP_STORE);

    // lookup hit first, then victim hit, then refill
    always_comb begin
        if (!head_valid)     state = lsu_pkg::ST_IDLE;
        else if (pkt1_empty) state = lsu_pkg::ST_WAIT_PKT1;
        else if (!pkt1_miss) state = lsu_pkg::ST_ISSUE;
        else if (vpkt_empty) state = lsu_pkg::ST_WAIT_VPKT;
        else if (!vpkt_miss) state = lsu_pkg::ST_ISSUE;   // served by victim CAM
        else if (pkt2_empty) state = lsu_pkg::ST_WAIT_PKT2;
        else                 state = lsu_pkg::ST_ISSUE;
    end

    assign issue            = (state == lsu_pkg::ST_ISSUE);
    assign pkt1_rd_en       = issue;
    assign vpkt_rd_en       = issue && pkt1_miss;
    assign pkt2_rd_en       = issue && pkt1_miss && vpkt_miss;
    assign victim_cam_en    = issue && pkt1_miss && !vpkt_miss;
    assign victim_cam_index = vpkt_vidx;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= lsu_pkg::ST_IDLE;
        end else begin
            state_q <= state;
        end
    end

    // only the refill can arrive while head, lookup and victim packets stay put
    a_refill_wait: assert property (@(posedge clk) disable iff (rst)
        (state_q == lsu_pkg::ST_WAIT_PKT2) |->
        (state inside {lsu_pkg::ST_WAIT_PKT2, lsu_pkg::ST_ISSUE}))
        else $error("left refill wait without issue");

endmodule

//--- src/lsu_load_align.sv
// load return path expecting cache read data one cycle after the issue cycle
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_load_align (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue,
    input  logic             is_load,
    input  lsu_pkg::funct3_t funct3,
    input  lsu_pkg::addr_t   addr,
    input  lsu_pkg::line_t   rd_line,
    output logic             mem_ready,
    output lsu_pkg::xdata_t  mem_out
);

    logic [`LSU_OFFSET_W-1:0] offset_q;
    lsu_pkg::funct3_t         funct3_q;
    logic                     load_q;
    lsu_pkg::line_t           shifted;
    lsu_pkg::xdata_t          field;
    lsu_pkg::xdata_t          ext;

    // stage 1 selects lined up with the cache read
    always_ff @(posedge clk) begin
        offset_q <= addr[`LSU_OFFSET_W-1:0];
        funct3_q <= funct3;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_q    <= 1'b0;
            mem_ready <= 1'b0;
        end else begin
            load_q    <= issue && is_load;
            mem_ready <= load_q;
        end
    end

    // addressed byte down to bit 0
    assign shifted = rd_line >> {offset_q, 3'b000};
    assign field   = shifted[`LSU_XLEN-1:0];

    always_comb begin
        case (funct3_q)
            `LSU_F3_LB:  ext = {{(`LSU_XLEN-8){field[7]}}, field[7:0]};
            `LSU_F3_LH:  ext = {{(`LSU_XLEN-16){field[15]}}, field[15:0]};
            `LSU_F3_LW:  ext = {{(`LSU_XLEN-32){field[31]}}, field[31:0]};
            `LSU_F3_LD:  ext = field;
            `LSU_F3_LBU: ext = {{(`LSU_XLEN-8){1'b0}}, field[7:0]};
            `LSU_F3_LHU: ext = {{(`LSU_XLEN-16){1'b0}}, field[15:0]};
            `LSU_F3_LWU: ext = {{(`LSU_XLEN-32){1'b0}}, field[31:0]};
            default:     ext = '0;   // undefined funct3
        endcase
    end

    always_ff @(posedge clk) begin
        mem_out <= ext;   // stage 2 result
    end

endmodule

//--- src/lsu_pkg.sv
// shared LSU types, widths follow the macros in lsu_defs.svh
`include "lsu_defs.svh"

package lsu_pkg;

    // byte address into the data cache
    typedef logic [`LSU_ADDR_W-1:0]         addr_t;

    // register-width load and store data
    typedef logic [`LSU_XLEN-1:0]           xdata_t;

    typedef logic [31:0]                    inst_t;     // raw instruction word

    // one full cache line and its byte enables
    typedef logic [`LSU_LINE_BYTES*8-1:0]   line_t;
    typedef logic [`LSU_LINE_BYTES-1:0]     line_en_t;

    typedef logic [3:0]                     way_en_t;   // one bit per way
    typedef logic [3:0]                     vidx_t;     // victim CAM entry
    typedef logic [2:0]                     funct3_t;

    // what the head request is doing this cycle
    typedef enum logic [2:0] {
        ST_IDLE,        // queue empty
        ST_WAIT_PKT1,   // no lookup packet yet
        ST_WAIT_VPKT,   // cache miss, victim packet missing
        ST_WAIT_PKT2,   // victim miss, refill line missing
        ST_ISSUE
    } issue_state_t;

endpackage

//--- src/lsu_req_queue.sv
// in-order request FIFO, pushing while full is illegal and depth must be a power of two
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_req_queue (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  lsu_pkg::inst_t  push_inst,
    input  lsu_pkg::addr_t  push_addr,
    input  lsu_pkg::xdata_t push_data,
    input  logic            pop,
    output logic            head_valid,
    output lsu_pkg::inst_t  head_inst,
    output lsu_pkg::addr_t  head_addr,
    output lsu_pkg::xdata_t head_data
);

    localparam int PTR_W = $clog2(`LSU_QUEUE_DEPTH);

    lsu_pkg::inst_t  inst_mem [`LSU_QUEUE_DEPTH];
    lsu_pkg::addr_t  addr_mem [`LSU_QUEUE_DEPTH];
    lsu_pkg::xdata_t data_mem [`LSU_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;     // one extra bit to hold a full queue
    logic             full;

    assign full       = (count == `LSU_QUEUE_DEPTH);
    assign head_valid = (count != '0);
    assign head_inst  = inst_mem[rd_ptr];
    assign head_addr  = addr_mem[rd_ptr];
    assign head_data  = data_mem[rd_ptr];

    // payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[wr_ptr] <= push_inst;
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // decode must respect the depth
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push into full request queue");

    // issue logic may only pop a present head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> head_valid)
        else $error("pop from empty request queue");

endmodule

//--- src/lsu_store_merge.sv
// builds the cache write line, store address must be naturally aligned to its size
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_store_merge (
    input  logic               issue,
    input  logic               is_store,
    input  lsu_pkg::funct3_t   funct3,
    input  lsu_pkg::addr_t     addr,
    input  lsu_pkg::xdata_t    store_data,
    input  lsu_pkg::line_t     fill_line,
    input  logic               pkt1_miss,
    output lsu_pkg::line_t     wr_line,
    output lsu_pkg::line_en_t  wr_en_byte
);

    logic [`LSU_OFFSET_W-1:0] offset;
    logic [3:0]               size_bytes;   // 1, 2, 4 or 8

    assign offset     = addr[`LSU_OFFSET_W-1:0];
    assign size_bytes = 4'd1 << funct3[1:0];

    always_comb begin
        logic [`LSU_OFFSET_W-1:0] bidx;
        logic [`LSU_OFFSET_W:0]   rel;       // byte position inside the store field
        logic [2:0]               lane;

        // refill line as the base, a miss writes the whole line
        wr_line    = fill_line;
        wr_en_byte = {`LSU_LINE_BYTES{pkt1_miss}};

        for (int b = 0; b < `LSU_LINE_BYTES; b++) begin
            bidx = b[`LSU_OFFSET_W-1:0];
            rel  = {1'b0, bidx} - {1'b0, offset};   // msb set when below offset
            lane = rel[2:0];
            if (is_store && !rel[`LSU_OFFSET_W] && (rel < size_bytes)) begin
                wr_line[b*8 +: 8] = store_data[lane*8 +: 8];
                wr_en_byte[b]     = 1'b1;
            end
        end

        if (!issue) begin
            wr_en_byte = '0;   // nothing reaches the cache without issue
        end
    end

endmodule

//--- src/lsu_top.sv
// load/store unit top, assumes aligned accesses and pops packet streams in order
`timescale 1ns/10ps

module lsu_top (
    input  logic               clk,
    input  logic               rst,
    // decode requests
    input  logic               lsu_req,
    input  lsu_pkg::inst_t     lsu_instruction,
    input  lsu_pkg::addr_t     lsu_addr,
    input  lsu_pkg::xdata_t    lsu_data,
    // lookup packet
    input  logic               pkt1_empty,
    input  logic               pkt1_miss,
    input  lsu_pkg::way_en_t   pkt1_ways,
    input  lsu_pkg::way_en_t   pkt1_evict,
    output logic               pkt1_rd_en,
    // victim packet
    input  logic               vpkt_empty,
    input  logic               vpkt_miss,
    input  lsu_pkg::vidx_t     vpkt_vidx,
    output logic               vpkt_rd_en,
    // refill packet
    input  logic               pkt2_empty,
    input  lsu_pkg::line_t     pkt2_line,
    output logic               pkt2_rd_en,
    // victim CAM
    output logic               victim_cam_en,
    output lsu_pkg::vidx_t     victim_cam_index,
    // data cache
    output lsu_pkg::way_en_t   cache_ens,
    output lsu_pkg::way_en_t   cache_evicts,
    output lsu_pkg::line_en_t  cache_wr_en_byte,
    output lsu_pkg::addr_t     cache_wr_addr,
    output lsu_pkg::addr_t     cache_rd_addr,
    output lsu_pkg::line_t     cache_wr_line,
    input  lsu_pkg::line_t     cache_rd_line,
    // load results
    output logic               mem_ready,
    output lsu_pkg::xdata_t    mem_out
);

    logic             head_valid;
    lsu_pkg::inst_t   head_inst;
    lsu_pkg::addr_t   head_addr;
    lsu_pkg::xdata_t  head_data;
    logic             issue;
    logic             is_load;
    logic             is_store;
    lsu_pkg::funct3_t funct3;

    assign cache_wr_addr = head_addr;
    assign cache_rd_addr = head_addr;
    assign cache_ens     = pkt1_ways;
    assign cache_evicts  = issue ? pkt1_evict : '0;

    lsu_req_queue req_queue_i (
        .clk        (clk),
        .rst        (rst),
        .push       (lsu_req),
        .push_inst  (lsu_instruction),
        .push_addr  (lsu_addr),
        .push_data  (lsu_data),
        .pop        (issue),
        .head_valid (head_valid),
        .head_inst  (head_inst),
        .head_addr  (head_addr),
        .head_data  (head_data)
    );

    lsu_issue_ctrl issue_ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .head_valid       (head_valid),
        .head_inst        (head_inst),
        .pkt1_empty       (pkt1_empty),
        .pkt1_miss        (pkt1_miss),
        .vpkt_empty       (vpkt_empty),
        .vpkt_miss        (vpkt_miss),
        .vpkt_vidx        (vpkt_vidx),
        .pkt2_empty       (pkt2_empty),
        .issue            (issue),
        .is_load          (is_load),
        .is_store         (is_store),
        .funct3           (funct3),
        .pkt1_rd_en       (pkt1_rd_en),
        .vpkt_rd_en       (vpkt_rd_en),
        .pkt2_rd_en       (pkt2_rd_en),
        .victim_cam_en    (victim_cam_en),
        .victim_cam_index (victim_cam_index)
    );

    lsu_store_merge store_merge_i (
        .issue      (issue),
        .is_store   (is_store),
        .funct3     (funct3),
        .addr       (head_addr),
        .store_data (head_data),
        .fill_line  (pkt2_line),
        .pkt1_miss  (pkt1_miss),
        .wr_line    (cache_wr_line),
        .wr_en_byte (cache_wr_en_byte)
    );

    lsu_load_align load_align_i (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .is_load   (is_load),
        .funct3    (funct3),
        .addr      (head_addr),
        .rd_line   (cache_rd_line),
        .mem_ready (mem_ready),
        .mem_out   (mem_out)
    );

endmodule

//--- verification/lsu_tb.sv
// cache model of this testbench covers byte addresses below 1 KiB only
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_tb;

    typedef struct packed {
        lsu_pkg::inst_t  inst;
        lsu_pkg::addr_t  addr;
        lsu_pkg::xdata_t data;
    } req_t;

    typedef struct packed {
        logic             miss;
        lsu_pkg::way_en_t ways;
        lsu_pkg::way_en_t evict;
    } lookup_t;

    typedef struct packed {
        logic           miss;
        lsu_pkg::vidx_t vidx;
    } victim_t;

    logic               clk;
    logic               rst;
    logic               lsu_req;
    lsu_pkg::inst_t     lsu_instruction;
    lsu_pkg::addr_t     lsu_addr;
    lsu_pkg::xdata_t    lsu_data;
    logic               pkt1_empty;
    logic               pkt1_miss;
    lsu_pkg::way_en_t   pkt1_ways;
    lsu_pkg::way_en_t   pkt1_evict;
    logic               pkt1_rd_en;
    logic               vpkt_empty;
    logic               vpkt_miss;
    lsu_pkg::vidx_t     vpkt_vidx;
    logic               vpkt_rd_en;
    logic               pkt2_empty;
    lsu_pkg::line_t     pkt2_line;
    logic               pkt2_rd_en;
    logic               victim_cam_en;
    lsu_pkg::vidx_t     victim_cam_index;
    lsu_pkg::way_en_t   cache_ens;
    lsu_pkg::way_en_t   cache_evicts;
    lsu_pkg::line_en_t  cache_wr_en_byte;
    lsu_pkg::addr_t     cache_wr_addr;
    lsu_pkg::addr_t     cache_rd_addr;
    lsu_pkg::line_t     cache_wr_line;
    lsu_pkg::line_t     cache_rd_line;
    logic               mem_ready;
    lsu_pkg::xdata_t    mem_out;

    req_t            req_q[$];     // requests inside the DUT queue
    lookup_t         p1_q[$];
    victim_t         v_q[$];
    lsu_pkg::line_t  p2_q[$];
    lsu_pkg::xdata_t sb_q[$];      // expected load results in order
    lsu_pkg::line_t  cache_mem [16];
    logic [1:0]      ld_pipe;
    logic [31:0]     seed;
    int              errors;
    int              checks;
    int              tests;
    int              tests_failed;
    int              test_err0;
    string           cur_test;

    lsu_top dut_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic lsu_pkg::line_t rand_line();
        lsu_pkg::line_t l;
        for (int i = 0; i < 16; i++) l[i*32 +: 32] = next_rand();
        return l;
    endfunction

    // random address inside the modeled lines and aligned to the access size
    function automatic lsu_pkg::addr_t rand_addr(lsu_pkg::funct3_t f3);
        lsu_pkg::addr_t a;
        a = next_rand() & 32'h3ff;
        return a & ~((32'd1 << f3[1:0]) - 32'd1);
    endfunction

    function automatic lsu_pkg::inst_t make_inst(logic [6:0] op, lsu_pkg::funct3_t f3);
        return {17'b0, f3, 5'b0, op};
    endfunction

    // field at the offset with sign fill unless funct3 bit 2 asks for zeros
    function automatic lsu_pkg::xdata_t expect_load(lsu_pkg::line_t line, int off,
                                                    lsu_pkg::funct3_t f3);
        lsu_pkg::xdata_t v;
        int              nb;
        nb = 1 << f3[1:0];
        v  = '0;
        for (int i = 0; i < nb; i++) v[i*8 +: 8] = line[(off + i)*8 +: 8];
        if (!f3[2] && v[nb*8-1]) begin
            for (int i = nb; i < 8; i++) v[i*8 +: 8] = 8'hff;
        end
        return v;
    endfunction

    function automatic logic ready_now();
        if (req_q.size() == 0 || p1_q.size() == 0) return 1'b0;
        if (!p1_q[0].miss) return 1'b1;          // lookup hit
        if (v_q.size() == 0) return 1'b0;
        if (!v_q[0].miss) return 1'b1;           // victim hit
        return p2_q.size() != 0;
    endfunction

    task automatic check_val(string what, logic [511:0] expected, logic [511:0] actual);
        checks++;
        assert (expected === actual) else begin
            $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_store(req_t r, logic miss, lsu_pkg::line_en_t wen,
                               lsu_pkg::line_t wline);
        int                nb;
        int                off;
        lsu_pkg::line_en_t exp_en;
        lsu_pkg::line_t    exp_line;
        lsu_pkg::line_t    mask;
        nb       = 1 << r.inst[13:12];
        off      = r.addr[5:0];
        exp_en   = miss ? '1 : '0;               // a miss fills the whole line
        exp_line = pkt2_line;
        for (int i = 0; i < nb; i++) begin
            exp_en[off + i]              = 1'b1;
            exp_line[(off + i)*8 +: 8] = r.data[i*8 +: 8];
        end
        for (int b = 0; b < 64; b++) mask[b*8 +: 8] = {8{exp_en[b]}};
        check_val("store enables", exp_en, wen);
        check_val("store line", exp_line & mask, wline & mask);
    endtask

    task automatic refresh_streams();
        pkt1_empty = (p1_q.size() == 0);
        vpkt_empty = (v_q.size() == 0);
        pkt2_empty = (p2_q.size() == 0);
        if (p1_q.size() != 0) {pkt1_miss, pkt1_ways, pkt1_evict} = p1_q[0];
        if (v_q.size() != 0) {vpkt_miss, vpkt_vidx} = v_q[0];
        if (p2_q.size() != 0) pkt2_line = p2_q[0];
    endtask

    // check at the edge and update models and inputs 1 ns later
    task automatic step();
        logic              iss;
        logic              p1m;
        logic              vm;
        logic              ld;
        req_t              r;
        lsu_pkg::line_en_t wen;
        lsu_pkg::line_t    wline;
        lsu_pkg::addr_t    waddr;
        lsu_pkg::addr_t    raddr;
        @(posedge clk);
        iss   = 1'b0;
        p1m   = 1'b0;
        vm    = 1'b0;
        ld    = 1'b0;
        wen   = cache_wr_en_byte;
        wline = cache_wr_line;
        waddr = cache_wr_addr;
        raddr = cache_rd_addr;
        if (!rst) begin
            iss = ready_now();
            if (iss) p1m = p1_q[0].miss;
            if (p1m) vm = v_q[0].miss;
            check_val("pkt1_rd_en", iss, pkt1_rd_en);
            check_val("vpkt_rd_en", iss && p1m, vpkt_rd_en);
            check_val("pkt2_rd_en", iss && p1m && vm, pkt2_rd_en);
            check_val("victim_cam_en", iss && p1m && !vm, victim_cam_en);
            if (iss && p1m && !vm) check_val("victim_cam_index", v_q[0].vidx, victim_cam_index);
            check_val("cache_evicts", iss ? p1_q[0].evict : 4'b0, cache_evicts);
            check_val("mem_ready", ld_pipe[1], mem_ready);
            if (mem_ready) begin
                assert (sb_q.size() != 0) else begin
                    $display("ERROR %s: load result returned with no load outstanding", cur_test);
                    errors++;
                end
                if (sb_q.size() != 0) check_val("mem_out", sb_q.pop_front(), mem_out);
            end
            if (!iss) begin
                check_val("idle cache_wr_en_byte", '0, wen);
            end else begin
                r = req_q.pop_front();
                check_val("cache_wr_addr", r.addr, waddr);
                check_val("cache_rd_addr", r.addr, raddr);
                check_val("cache_ens", p1_q[0].ways, cache_ens);
                if (r.inst[6:0] == `LSU_OP_STORE) check_store(r, p1m, wen, wline);
                ld = (r.inst[6:0] == `LSU_OP_LOAD);
                void'(p1_q.pop_front());
                if (p1m) void'(v_q.pop_front());
                if (p1m && vm) void'(p2_q.pop_front());
            end
            ld_pipe = {ld_pipe[0], ld};
            if (lsu_req) req_q.push_back({lsu_instruction, lsu_addr, lsu_data});
        end
        #1;
        for (int b = 0; b < 64; b++) begin
            if (wen[b]) cache_mem[waddr[9:6]][b*8 +: 8] = wline[b*8 +: 8];
        end
        cache_rd_line = cache_mem[raddr[9:6]];   // read after write and one cycle late
        if (ld) sb_q.push_back(expect_load(cache_mem[r.addr[9:6]], r.addr[5:0], r.inst[14:12]));
        lsu_req = 1'b0;
        refresh_streams();
    endtask

    task automatic push_req(logic [6:0] op, lsu_pkg::funct3_t f3, lsu_pkg::addr_t a,
                            lsu_pkg::xdata_t d);
        lsu_req         = 1'b1;
        lsu_instruction = make_inst(op, f3);
        lsu_addr        = a;
        lsu_data        = d;
        step();
    endtask

    task automatic add_lookup(logic miss);
        p1_q.push_back({miss, 4'(next_rand()), 4'(next_rand())});
        refresh_streams();
    endtask

    task automatic add_victim(logic miss);
        v_q.push_back({miss, 4'(next_rand())});
        refresh_streams();
    endtask

    task automatic add_refill();
        p2_q.push_back(rand_line());
        refresh_streams();
    endtask

    function automatic logic busy();
        return req_q.size() != 0 || p1_q.size() != 0 || v_q.size() != 0
            || p2_q.size() != 0 || sb_q.size() != 0 || ld_pipe != 2'b00;
    endfunction

    task automatic drain();
        int n;
        n = 0;
        while (busy() && n < 100) begin
            step();
            n++;
        end
        if (busy()) begin
            errors++;
            $display("ERROR %s: requests or load results still outstanding after 100 cycles",
                     cur_test);
            $display("Simulation finished: FAIL");
            $finish;
        end
    endtask

    task automatic begin_test(string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - test_err0);
        end else begin
            $display("test %s: passed", cur_test);
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        lsu_req         = 1'b0;
        lsu_instruction = '0;
        lsu_addr        = '0;
        lsu_data        = '0;
        pkt1_miss       = 1'b0;
        pkt1_ways       = '0;
        pkt1_evict      = '0;
        vpkt_miss       = 1'b0;
        vpkt_vidx       = '0;
        pkt2_line       = '0;
        cache_rd_line   = '0;
        seed            = 32'd42552;
        ld_pipe         = 2'b00;
        errors          = 0;
        checks          = 0;
        tests           = 0;
        tests_failed    = 0;
        cur_test        = "reset";
        refresh_streams();
        for (int i = 0; i < 16; i++) cache_mem[i] = rand_line();
        repeat (4) step();
        rst = 1'b0;

        begin_test("reset_idle");
        repeat (3) step();
        push_req(`LSU_OP_LOAD, `LSU_F3_LD, rand_addr(`LSU_F3_LD), '0);
        repeat (3) step();                         // request without lookup packet
        add_lookup(1'b0);
        drain();
        add_lookup(1'b0);
        repeat (3) step();                         // lookup packet without request
        push_req(`LSU_OP_STORE, `LSU_F3_SW, rand_addr(`LSU_F3_SW), {next_rand(), next_rand()});
        drain();
        end_test();

        begin_test("store_hit");
        for (int f = 0; f < 4; f++) begin
            add_lookup(1'b0);
            push_req(`LSU_OP_STORE, 3'(f), rand_addr(3'(f)), {next_rand(), next_rand()});
            drain();
        end
        end_test();

        begin_test("store_miss");
        for (int f = 0; f < 4; f++) begin
            add_lookup(1'b1);
            add_victim(1'b1);
            add_refill();
            push_req(`LSU_OP_STORE, 3'(f), rand_addr(3'(f)), {next_rand(), next_rand()});
            drain();
        end
        end_test();

        begin_test("gating");
        add_lookup(1'b1);
        push_req(`LSU_OP_LOAD, `LSU_F3_LW, rand_addr(`LSU_F3_LW), '0);
        repeat (4) step();                         // victim stream empty
        add_victim(1'b0);
        drain();
        add_lookup(1'b1);
        add_victim(1'b1);
        push_req(`LSU_OP_STORE, `LSU_F3_SD, rand_addr(`LSU_F3_SD), {next_rand(), next_rand()});
        repeat (4) step();                         // refill stream empty
        add_refill();
        drain();
        end_test();

        begin_test("loads");
        for (int f = 0; f < 7; f++) add_lookup(1'b0);
        for (int f = 0; f < 7; f++) begin
            push_req(`LSU_OP_LOAD, 3'(f), rand_addr(3'(f)), '0);   // back to back
        end
        drain();
        end_test();

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests - tests_failed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
